// File: include/bus_consts.svh
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Core side address width, also the IFU and LSU data width
`define BUS_ADDR_W 32

// External AXI master port
`define SOC_DATA_W 64

// Machine timer
`define MTIME_W 64

// CLINT decode window, both ends inclusive
`define CLINT_BASE 32'h0200_0000
`define CLINT_LAST 32'h0200_FFFF

// Offsets inside the CLINT window
`define CLINT_OFS_W  16
`define MTIME_LO_OFS 16'hBFF8
`define MTIME_HI_OFS 16'hBFFC

`endif

// File: source/bus_pkg.sv
`include "bus_consts.svh"

package bus_pkg;

	// Read owner of the crossbar
	typedef enum logic [1:0] {
		GRANT_IDLE,
		GRANT_IFU,
		GRANT_LSU
	} grant_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

	// AXI size code for a 4-byte transfer
	localparam logic [2:0] SIZE_WORD = 3'b010;

	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic [2:0]             size;
	} ar_t;

	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] data;
		resp_e                  resp;
	} r32_t;

	typedef struct packed {
		logic [`SOC_DATA_W-1:0] data;
		resp_e                  resp;
	} r64_t;

	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic [2:0]             size;
	} aw_t;

	// LSU side write data, one 32-bit lane
	typedef struct packed {
		logic [`BUS_ADDR_W-1:0]   data;
		logic [`BUS_ADDR_W/8-1:0] strb;
	} w32_t;

	typedef struct packed {
		logic [`SOC_DATA_W-1:0]   data;
		logic [`SOC_DATA_W/8-1:0] strb;
		logic                     last;
	} w64_t;

endpackage

// File: source/clint.sv
`timescale 1ns/1ps
`include "bus_consts.svh"

module clint import bus_pkg::*; (
	input  logic clock,
	input  logic reset,

	input  logic arvalid,
	output logic arready,
	input  ar_t  ar,

	output logic rvalid,
	input  logic rready,
	output r32_t r
);

	logic [`MTIME_W-1:0]     mtime_q;
	logic                    rvalid_q;
	r32_t                    r_q;
	logic [`CLINT_OFS_W-1:0] ofs;
	logic [`BUS_ADDR_W-1:0]  rd_word;

	always_ff @(posedge clock) begin
		if (reset)
			mtime_q <= '0;
		else
			mtime_q <= mtime_q + 1'b1;
	end

	// Offset decode inside the window
	assign ofs = ar.addr[`CLINT_OFS_W-1:0];

	always_comb begin
		case (ofs)
			`MTIME_LO_OFS: rd_word = mtime_q[`BUS_ADDR_W-1:0];
			`MTIME_HI_OFS: rd_word = mtime_q[`MTIME_W-1:`BUS_ADDR_W];
			default:       rd_word = '0;
		endcase
	end

	assign arready = !rvalid_q;

	always_ff @(posedge clock) begin
		if (reset)
			rvalid_q <= 1'b0;
		else if (arvalid && arready)
			rvalid_q <= 1'b1;
		else if (rready)
			rvalid_q <= 1'b0;
	end

	// One response entry, loaded with the value at the ar handshake
	always_ff @(posedge clock) begin
		if (arvalid && arready) begin
			r_q.data <= rd_word;
			r_q.resp <= RESP_OKAY;
		end
	end

	assign rvalid = rvalid_q;
	assign r      = r_q;

endmodule

// File: source/bus_xbar.sv
`timescale 1ns/1ps
`include "bus_consts.svh"

module bus_xbar import bus_pkg::*; (
	input  logic  clock,
	input  logic  reset,

	input  logic  ifu_arvalid,
	output logic  ifu_arready,
	input  ar_t   ifu_ar,
	output logic  ifu_rvalid,
	input  logic  ifu_rready,
	output r32_t  ifu_r,

	input  logic  lsu_arvalid,
	output logic  lsu_arready,
	input  ar_t   lsu_ar,
	output logic  lsu_rvalid,
	input  logic  lsu_rready,
	output r32_t  lsu_r,

	input  logic  lsu_awvalid,
	output logic  lsu_awready,
	input  aw_t   lsu_aw,
	input  logic  lsu_wvalid,
	output logic  lsu_wready,
	input  w32_t  lsu_w,
	output logic  lsu_bvalid,
	input  logic  lsu_bready,
	output resp_e lsu_bresp,

	output logic  soc_arvalid,
	input  logic  soc_arready,
	output ar_t   soc_ar,
	input  logic  soc_rvalid,
	output logic  soc_rready,
	input  r64_t  soc_r,
	output logic  soc_awvalid,
	input  logic  soc_awready,
	output aw_t   soc_aw,
	output logic  soc_wvalid,
	input  logic  soc_wready,
	output w64_t  soc_w,
	input  logic  soc_bvalid,
	output logic  soc_bready,
	input  resp_e soc_bresp,

	output logic  clint_arvalid,
	input  logic  clint_arready,
	output ar_t   clint_ar,
	input  logic  clint_rvalid,
	output logic  clint_rready,
	input  r32_t  clint_r
);

	grant_e grant_q, grant_d;
	logic   ar_done_q;
	logic   tgt_clint_q;
	logic   half_q;
	logic   lane_q;
	logic   lane_hi;
	logic   lsu_in_clint;
	logic   ifu_go, lsu_go;
	logic   ar_hs;
	r32_t   soc_r32;

	assign lsu_in_clint = (lsu_ar.addr >= `CLINT_BASE) && (lsu_ar.addr <= `CLINT_LAST);

	// The ar channel opens once per grant
	assign ifu_go = (grant_q == GRANT_IFU) && !ar_done_q;
	assign lsu_go = (grant_q == GRANT_LSU) && !ar_done_q;
	assign ar_hs  = (ifu_arvalid && ifu_arready) || (lsu_arvalid && lsu_arready);

	always_comb begin
		grant_d = grant_q;
		case (grant_q)
			GRANT_IDLE: begin
				if (ifu_arvalid)
					grant_d = GRANT_IFU;
				else if (lsu_arvalid)
					grant_d = GRANT_LSU;
			end
			GRANT_IFU: begin
				if (ifu_rvalid && ifu_rready)
					grant_d = GRANT_IDLE;
			end
			GRANT_LSU: begin
				if (lsu_rvalid && lsu_rready)
					grant_d = GRANT_IDLE;
			end
			default: grant_d = GRANT_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			grant_q     <= GRANT_IDLE;
			ar_done_q   <= 1'b0;
			tgt_clint_q <= 1'b0;
		end else begin
			grant_q   <= grant_d;
			ar_done_q <= (grant_d != GRANT_IDLE) && (ar_done_q || ar_hs);
			if (grant_q == GRANT_IDLE)
				tgt_clint_q <= lsu_in_clint;
		end
	end

	// Word half of the granted read
	always_ff @(posedge clock) begin
		if (grant_q == GRANT_IDLE)
			half_q <= ifu_arvalid ? ifu_ar.addr[2] : lsu_ar.addr[2];
	end

	always_comb begin
		soc_ar = lsu_ar;
		if (grant_q == GRANT_IFU) begin
			soc_ar.addr = ifu_ar.addr;
			soc_ar.size = SIZE_WORD;
		end
	end

	assign clint_ar      = lsu_ar;
	assign soc_arvalid   = (ifu_go && ifu_arvalid) || (lsu_go && !tgt_clint_q && lsu_arvalid);
	assign clint_arvalid = lsu_go && tgt_clint_q && lsu_arvalid;
	assign ifu_arready   = ifu_go && soc_arready;
	assign lsu_arready   = lsu_go && (tgt_clint_q ? clint_arready : soc_arready);

	assign soc_r32.data = half_q ? soc_r.data[`SOC_DATA_W-1:`BUS_ADDR_W]
		: soc_r.data[`BUS_ADDR_W-1:0];
	assign soc_r32.resp = soc_r.resp;

	assign soc_rready   = ((grant_q == GRANT_IFU) && ifu_rready)
		|| ((grant_q == GRANT_LSU) && !tgt_clint_q && lsu_rready);
	assign clint_rready = (grant_q == GRANT_LSU) && tgt_clint_q && lsu_rready;
	assign ifu_rvalid   = (grant_q == GRANT_IFU) && soc_rvalid;
	assign lsu_rvalid   = (grant_q == GRANT_LSU) && (tgt_clint_q ? clint_rvalid : soc_rvalid);
	assign ifu_r        = soc_r32;
	assign lsu_r        = tgt_clint_q ? clint_r : soc_r32;

	// Write lane follows the live address while aw is still up
	always_ff @(posedge clock) begin
		if (lsu_awvalid && lsu_awready)
			lane_q <= lsu_aw.addr[2];
	end

	assign lane_hi = lsu_awvalid ? lsu_aw.addr[2] : lane_q;

	always_comb begin
		if (lane_hi) begin
			soc_w.data = {lsu_w.data, {`BUS_ADDR_W{1'b0}}};
			soc_w.strb = {lsu_w.strb, {(`BUS_ADDR_W/8){1'b0}}};
		end else begin
			soc_w.data = {{`BUS_ADDR_W{1'b0}}, lsu_w.data};
			soc_w.strb = {{(`BUS_ADDR_W/8){1'b0}}, lsu_w.strb};
		end
		soc_w.last = lsu_wvalid;
	end

	assign soc_awvalid = lsu_awvalid;
	assign lsu_awready = soc_awready;
	assign soc_aw      = lsu_aw;
	assign soc_wvalid  = lsu_wvalid;
	assign lsu_wready  = soc_wready;
	assign lsu_bvalid  = soc_bvalid;
	assign soc_bready  = lsu_bready;
	assign lsu_bresp   = soc_bresp;

endmodule

// File: source/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top import bus_pkg::*; (
	input  logic  clock,
	input  logic  reset,

	input  logic  ifu_arvalid,
	output logic  ifu_arready,
	input  ar_t   ifu_ar,
	output logic  ifu_rvalid,
	input  logic  ifu_rready,
	output r32_t  ifu_r,

	input  logic  lsu_arvalid,
	output logic  lsu_arready,
	input  ar_t   lsu_ar,
	output logic  lsu_rvalid,
	input  logic  lsu_rready,
	output r32_t  lsu_r,
	input  logic  lsu_awvalid,
	output logic  lsu_awready,
	input  aw_t   lsu_aw,
	input  logic  lsu_wvalid,
	output logic  lsu_wready,
	input  w32_t  lsu_w,
	output logic  lsu_bvalid,
	input  logic  lsu_bready,
	output resp_e lsu_bresp,

	output logic  soc_arvalid,
	input  logic  soc_arready,
	output ar_t   soc_ar,
	input  logic  soc_rvalid,
	output logic  soc_rready,
	input  r64_t  soc_r,
	output logic  soc_awvalid,
	input  logic  soc_awready,
	output aw_t   soc_aw,
	output logic  soc_wvalid,
	input  logic  soc_wready,
	output w64_t  soc_w,
	input  logic  soc_bvalid,
	output logic  soc_bready,
	input  resp_e soc_bresp
);

	// Crossbar to CLINT read channel
	logic clint_arvalid, clint_arready;
	ar_t  clint_ar;
	logic clint_rvalid, clint_rready;
	r32_t clint_r;

	bus_xbar xbar (.*);

	clint timer (
		.clock   (clock),
		.reset   (reset),
		.arvalid (clint_arvalid),
		.arready (clint_arready),
		.ar      (clint_ar),
		.rvalid  (clint_rvalid),
		.rready  (clint_rready),
		.r       (clint_r)
	);

endmodule

// File: test/soc_bus_top_checker.sv
`timescale 1ns/1ps
`include "bus_consts.svh"

module soc_bus_top_checker import bus_pkg::*; (
	input logic  clock,
	input logic  reset,
	input logic  ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready,
	input ar_t   ifu_ar,
	input r32_t  ifu_r,
	input logic  lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready,
	input ar_t   lsu_ar,
	input r32_t  lsu_r,
	input logic  lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready,
	input logic  lsu_bvalid, lsu_bready,
	input aw_t   lsu_aw,
	input w32_t  lsu_w,
	input resp_e lsu_bresp,
	input logic  soc_arvalid, soc_arready, soc_rvalid, soc_rready,
	input ar_t   soc_ar,
	input logic  soc_awvalid, soc_awready, soc_wvalid, soc_wready,
	input logic  soc_bvalid, soc_bready,
	input aw_t   soc_aw,
	input w64_t  soc_w
);

	localparam logic [`BUS_ADDR_W-1:0] MTIME_LO_ADDR = `CLINT_BASE + 32'(`MTIME_LO_OFS);

	int                     err_count = 0;
	logic                   seen_req;
	logic                   soc_pend;
	logic                   have_lo;
	logic [`BUS_ADDR_W-1:0] soc_addr_q;
	logic [`BUS_ADDR_W-1:0] lsu_addr_q;
	logic [`BUS_ADDR_W-1:0] last_lo;
	logic [`BUS_ADDR_W-1:0] soc_half;
	logic [`BUS_ADDR_W-1:0] soc_base;
	logic [`SOC_DATA_W-1:0] lane_data;
	logic [7:0]             lane_strb;

	function automatic logic in_window(input logic [`BUS_ADDR_W-1:0] addr);
		return (addr >= `CLINT_BASE) && (addr <= `CLINT_LAST);
	endfunction

	// Expected half of the memory model word
	assign soc_base  = soc_addr_q & ~32'h4;
	assign soc_half  = soc_addr_q[2] ? ~soc_base : soc_base;
	assign lane_data = {32'h0, lsu_w.data} << (lsu_aw.addr[2] ? 32 : 0);
	assign lane_strb = {4'h0, lsu_w.strb} << (lsu_aw.addr[2] ? 4 : 0);

	always_ff @(posedge clock) begin
		if (reset) begin
			seen_req <= 1'b0;
			soc_pend <= 1'b0;
			have_lo  <= 1'b0;
		end else begin
			if (ifu_arvalid || lsu_arvalid)
				seen_req <= 1'b1;
			if (soc_arvalid && soc_arready) begin
				soc_pend   <= 1'b1;
				soc_addr_q <= soc_ar.addr;
			end else if (soc_rvalid && soc_rready) begin
				soc_pend <= 1'b0;
			end
			if (lsu_arvalid && lsu_arready)
				lsu_addr_q <= lsu_ar.addr;
			if (lsu_rvalid && lsu_rready && lsu_addr_q == MTIME_LO_ADDR) begin
				have_lo <= 1'b1;
				last_lo <= lsu_r.data;
			end
		end
	end

	quiet_after_reset: assert property (@(posedge clock) disable iff (reset)
		!seen_req |-> !soc_arvalid && !ifu_rvalid && !lsu_rvalid)
		else begin
			err_count++;
			$error("Read channel active before any request");
		end

	one_rvalid: assert property (@(posedge clock) disable iff (reset)
		!(ifu_rvalid && lsu_rvalid))
		else begin
			err_count++;
			$error("IFU and LSU responses valid in the same cycle");
		end

	single_outstanding: assert property (@(posedge clock) disable iff (reset)
		$rose(soc_arvalid) |-> !soc_pend)
		else begin
			err_count++;
			$error("SoC read issued while another was outstanding");
		end

	ifu_first: assert property (@(posedge clock) disable iff (reset)
		$rose(ifu_arvalid) && $rose(lsu_arvalid) && !soc_pend
		|=> soc_arvalid && soc_ar.addr == ifu_ar.addr)
		else begin
			err_count++;
			$error("Fail soc_ar.addr %h expected %h", soc_ar.addr, ifu_ar.addr);
		end

	ifu_to_soc: assert property (@(posedge clock) disable iff (reset)
		ifu_arvalid && ifu_arready |-> soc_arvalid && soc_ar.addr == ifu_ar.addr)
		else begin
			err_count++;
			$error("Fail soc_ar.addr %h expected %h", soc_ar.addr, ifu_ar.addr);
		end

	ifu_data: assert property (@(posedge clock) disable iff (reset)
		ifu_rvalid |-> ifu_r.data == soc_half && ifu_r.resp == RESP_OKAY)
		else begin
			err_count++;
			$error("Fail ifu_r %h expected %h", ifu_r, {soc_half, RESP_OKAY});
		end

	ifu_stall: assert property (@(posedge clock) disable iff (reset)
		ifu_rvalid && !ifu_rready |=> ifu_rvalid && $stable(ifu_r))
		else begin
			err_count++;
			$error("IFU response changed while rready was low");
		end

	lsu_to_soc: assert property (@(posedge clock) disable iff (reset)
		lsu_arvalid && lsu_arready && !in_window(lsu_ar.addr)
		|-> soc_arvalid && soc_ar == lsu_ar)
		else begin
			err_count++;
			$error("Fail soc_ar %h expected %h", soc_ar, lsu_ar);
		end

	clint_not_soc: assert property (@(posedge clock) disable iff (reset)
		lsu_arvalid && in_window(lsu_ar.addr) && !ifu_arvalid |-> !soc_arvalid)
		else begin
			err_count++;
			$error("CLINT read leaked to the SoC port");
		end

	lsu_soc_data: assert property (@(posedge clock) disable iff (reset)
		lsu_rvalid && !in_window(lsu_addr_q)
		|-> lsu_r.data == soc_half && lsu_r.resp == RESP_OKAY)
		else begin
			err_count++;
			$error("Fail lsu_r %h expected %h", lsu_r, {soc_half, RESP_OKAY});
		end

	mtime_rising: assert property (@(posedge clock) disable iff (reset)
		lsu_rvalid && lsu_rready && lsu_addr_q == MTIME_LO_ADDR && have_lo
		|-> lsu_r.data > last_lo)
		else begin
			err_count++;
			$error("Fail lsu_r.data %h not above %h", lsu_r.data, last_lo);
		end

	unmapped_zero: assert property (@(posedge clock) disable iff (reset)
		lsu_rvalid && in_window(lsu_addr_q)
		&& lsu_addr_q[`CLINT_OFS_W-1:0] != `MTIME_LO_OFS
		&& lsu_addr_q[`CLINT_OFS_W-1:0] != `MTIME_HI_OFS
		|-> lsu_r.data == '0 && lsu_r.resp == RESP_OKAY)
		else begin
			err_count++;
			$error("Fail lsu_r %h expected %h", lsu_r, 34'h0);
		end

	write_lane: assert property (@(posedge clock) disable iff (reset)
		lsu_awvalid && lsu_wvalid |-> soc_w.data == lane_data && soc_w.strb == lane_strb)
		else begin
			err_count++;
			$error("Fail soc_w.data %h soc_w.strb %h expected %h %h",
				soc_w.data, soc_w.strb, lane_data, lane_strb);
		end

	write_last: assert property (@(posedge clock) disable iff (reset)
		soc_w.last == lsu_wvalid)
		else begin
			err_count++;
			$error("Fail soc_w.last %h expected %h", soc_w.last, lsu_wvalid);
		end

	write_addr: assert property (@(posedge clock) disable iff (reset)
		soc_awvalid == lsu_awvalid && (!lsu_awvalid || soc_aw == lsu_aw))
		else begin
			err_count++;
			$error("Fail soc_awvalid %h soc_aw %h expected %h %h",
				soc_awvalid, soc_aw, lsu_awvalid, lsu_aw);
		end

	write_handshake: assert property (@(posedge clock) disable iff (reset)
		soc_wvalid == lsu_wvalid && lsu_awready == soc_awready
		&& lsu_wready == soc_wready && lsu_bvalid == soc_bvalid
		&& soc_bready == lsu_bready)
		else begin
			err_count++;
			$error("Write handshake signals did not pass through the crossbar");
		end

	write_resp: assert property (@(posedge clock) disable iff (reset)
		lsu_bvalid && lsu_bready |-> lsu_bresp == RESP_OKAY)
		else begin
			err_count++;
			$error("Fail lsu_bresp %h expected %h", lsu_bresp, RESP_OKAY);
		end

endmodule

bind soc_bus_top soc_bus_top_checker chk (.*);

// File: test/soc_bus_top_tb.sv
`timescale 1ns/1ps
`include "bus_consts.svh"

module soc_bus_top_tb import bus_pkg::*; ();

	localparam int WAIT_LIMIT = 100;

	logic  clock, reset;
	logic  ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
	ar_t   ifu_ar;
	r32_t  ifu_r;
	logic  lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
	ar_t   lsu_ar;
	r32_t  lsu_r;
	logic  lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
	aw_t   lsu_aw;
	w32_t  lsu_w;
	resp_e lsu_bresp;
	logic  soc_arvalid, soc_arready, soc_rvalid, soc_rready;
	ar_t   soc_ar;
	r64_t  soc_r;
	logic  soc_awvalid, soc_awready, soc_wvalid, soc_wready, soc_bvalid, soc_bready;
	aw_t   soc_aw;
	w64_t  soc_w;
	resp_e soc_bresp;
	logic [15:0] stim_lfsr;

	soc_bus_top uut (.*);

	always #10 clock = ~clock;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [31:0] lfsr_take(inout logic [15:0] state, input int n);
		logic [31:0] v;
		logic        fb;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
			state = {state[14:0], fb};
			v     = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [63:0] slave_word(input logic [31:0] addr);
		logic [31:0] base;
		base = addr & ~32'h4;
		return {~base, base};
	endfunction

	// 0 ar handshake, 1 rvalid, 2 r handshake, 3 aw handshake, 4 b handshake
	function automatic logic seen(input int kind, input logic use_lsu);
		case (kind)
			0: return use_lsu ? lsu_arvalid && lsu_arready : ifu_arvalid && ifu_arready;
			1: return use_lsu ? lsu_rvalid : ifu_rvalid;
			2: return use_lsu ? lsu_rvalid && lsu_rready : ifu_rvalid && ifu_rready;
			3: return lsu_awvalid && lsu_awready;
			default: return lsu_bvalid && lsu_bready;
		endcase
	endfunction

	task automatic wait_for(input int kind, input logic use_lsu, input string what);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
			if (cycles > WAIT_LIMIT)
				fail_run({what, " did not happen before the timeout"});
		end while (!seen(kind, use_lsu));
	endtask

	task automatic read_access(input logic use_lsu, input logic [31:0] addr, input int hold);
		ar_t req;
		req = '{addr: addr, size: SIZE_WORD};
		@(negedge clock);
		if (use_lsu) begin
			lsu_ar      = req;
			lsu_arvalid = 1'b1;
		end else begin
			ifu_ar      = req;
			ifu_arvalid = 1'b1;
		end
		wait_for(0, use_lsu, "Read address handshake");
		@(negedge clock);
		lsu_arvalid = use_lsu ? 1'b0 : lsu_arvalid;
		ifu_arvalid = use_lsu ? ifu_arvalid : 1'b0;
		wait_for(1, use_lsu, "Read response valid");
		// Response held back for hold cycles
		repeat (hold + 1) @(negedge clock);
		lsu_rready = use_lsu ? 1'b1 : lsu_rready;
		ifu_rready = use_lsu ? ifu_rready : 1'b1;
		wait_for(2, use_lsu, "Read response handshake");
		@(negedge clock);
		lsu_rready = use_lsu ? 1'b0 : lsu_rready;
		ifu_rready = use_lsu ? ifu_rready : 1'b0;
	endtask

	task automatic write_access(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		@(negedge clock);
		lsu_aw      = '{addr: addr, size: SIZE_WORD};
		lsu_w       = '{data: data, strb: strb};
		lsu_awvalid = 1'b1;
		lsu_wvalid  = 1'b1;
		wait_for(3, 1'b1, "Write address handshake");
		@(negedge clock);
		lsu_awvalid = 1'b0;
		lsu_wvalid  = 1'b0;
		wait_for(4, 1'b1, "Write response handshake");
	endtask

	// SoC memory slave serving one read at a time
	initial begin : soc_slave
		logic [15:0] slave_lfsr;
		logic [31:0] addr;
		logic        ar_hs, r_hs, w_hs, b_hs, busy;
		int          delay;
		slave_lfsr  = 16'd13;
		busy        = 1'b0;
		delay       = 0;
		soc_arready = 1'b0;
		soc_rvalid  = 1'b0;
		soc_r       = '{data: '0, resp: RESP_OKAY};
		soc_awready = 1'b0;
		soc_wready  = 1'b0;
		soc_bvalid  = 1'b0;
		soc_bresp   = RESP_OKAY;
		forever begin
			@(posedge clock);
			ar_hs = soc_arvalid && soc_arready;
			r_hs  = soc_rvalid && soc_rready;
			w_hs  = soc_wvalid && soc_wready;
			b_hs  = soc_bvalid && soc_bready;
			if (ar_hs)
				addr = soc_ar.addr;
			@(negedge clock);
			if (r_hs) begin
				soc_rvalid = 1'b0;
				busy       = 1'b0;
			end
			if (ar_hs) begin
				busy  = 1'b1;
				delay = int'(lfsr_take(slave_lfsr, 2) % 32'd3) + 1;
			end else if (busy && !soc_rvalid) begin
				delay--;
				if (delay == 0) begin
					soc_rvalid = 1'b1;
					soc_r      = '{data: slave_word(addr), resp: RESP_OKAY};
				end
			end
			soc_arready = !busy && (lfsr_take(slave_lfsr, 1) != 32'd0);
			if (b_hs)
				soc_bvalid = 1'b0;
			if (w_hs)
				soc_bvalid = 1'b1;
			soc_awready = !soc_bvalid;
			soc_wready  = !soc_bvalid;
		end
	end

	always @(negedge clock) begin
		if (uut.chk.err_count != 0)
			fail_run("The bound checker flagged an assertion");
	end

	initial begin
		logic [31:0] addr, data, rnd;
		int          i;
		clock       = 1'b0;
		reset       = 1'b1;
		stim_lfsr   = 16'd13;
		ifu_arvalid = 1'b0;
		ifu_ar      = '0;
		ifu_rready  = 1'b0;
		lsu_arvalid = 1'b0;
		lsu_ar      = '0;
		lsu_rready  = 1'b0;
		lsu_awvalid = 1'b0;
		lsu_aw      = '0;
		lsu_wvalid  = 1'b0;
		lsu_w       = '0;
		lsu_bready  = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		repeat (4) @(negedge clock);

		// Random fetches with random response stalls
		for (i = 0; i < 8; i++) begin
			addr = lfsr_take(stim_lfsr, 30) << 2;
			read_access(1'b0, addr, int'(lfsr_take(stim_lfsr, 2)));
		end

		// Same cycle requests where the IFU wins
		fork
			read_access(1'b0, 32'h0000_1000, 0);
			read_access(1'b1, 32'h8000_2004, 0);
		join
		fork
			read_access(1'b0, 32'h0000_1004, 1);
			read_access(1'b1, `CLINT_BASE + 32'(`MTIME_LO_OFS), 0);
		join

		for (i = 0; i < 6; i++) begin
			addr = 32'h8000_0000 | (lfsr_take(stim_lfsr, 29) << 2);
			read_access(1'b1, addr, int'(lfsr_take(stim_lfsr, 2)));
		end

		// Timer reads and one unmapped offset
		read_access(1'b1, `CLINT_BASE + 32'(`MTIME_LO_OFS), 0);
		repeat (3) @(negedge clock);
		read_access(1'b1, `CLINT_BASE + 32'(`MTIME_LO_OFS), 2);
		read_access(1'b1, `CLINT_BASE + 32'(`MTIME_HI_OFS), 0);
		read_access(1'b1, `CLINT_BASE + 32'h0000_0100, 1);

		for (i = 0; i < 6; i++) begin
			addr = lfsr_take(stim_lfsr, 30) << 2;
			data = lfsr_take(stim_lfsr, 32);
			rnd  = lfsr_take(stim_lfsr, 4);
			write_access(addr, data, rnd[3:0]);
		end

		read_access(1'b0, 32'h0000_2040, 4);
		read_access(1'b0, 32'h0000_2044, 3);
		repeat (5) @(negedge clock);

		if (uut.chk.err_count == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			fail_run("The bound checker counted assertion failures");
		end
	end

endmodule

// File: soc_bus_top.f
+incdir+include
source/bus_pkg.sv
source/clint.sv
source/bus_xbar.sv
source/soc_bus_top.sv
test/soc_bus_top_checker.sv
test/soc_bus_top_tb.sv

// File: Makefile
# Verilator build and run for the SoC bus fabric

VERILATOR ?= verilator
TOP       ?= soc_bus_top_tb
FILELIST  ?= soc_bus_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard include/*.svh source/*.sv test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator status is not trusted
run: compile
	./$(SIM_BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "Regression passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
